/* ibuf_top.f */
hdl/ibuf_pkg.sv
hdl/ibuf_entry_array.sv
hdl/ibuf_push_ctrl.sv
hdl/ibuf_pop_ctrl.sv
hdl/ibuf_top.sv
dv/ibuf_tb_checks.sv
dv/ibuf_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the instruction buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=ibuf_sim

verilator --binary --timing --assert -f ibuf_top.f --top-module ibuf_tb \
  -Mdir obj_dir -o "$SIM"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* dv/ibuf_tb.sv */
// Testbench for the instruction buffer
// Random fetch, pop and cancel stream against a halfword queue reference model

`timescale 1ns/100ps

module ibuf_tb;

  import ibuf_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYC     = 3;
  localparam int NUM_CYC     = 1800;
  localparam int PHASE_LEN   = 200;  // Cycles per pop-rate phase
  localparam int WATCHDOG_NS = (RST_CYC + NUM_CYC + 50) * CLK_PERIOD;

  logic                 ibuf_pop_upd_clk;
  logic                 cpurst_b;
  logic                 trans_cmplt;
  logic [FETCH_W-1:0]   fetch_data;
  logic                 unalign_fetch;
  logic                 acc_err;
  logic                 inst_fetch;
  logic                 pop_en;
  logic                 inst_vld;
  logic [FETCH_W-1:0]   inst;
  logic                 inst32;
  logic                 inst32_low;
  logic                 expt_vld;
  logic                 expt_cur;
  logic                 empty;
  logic                 ifcancel;

  // Reference model state
  half_t                q_half [$];
  logic                 q_err [$];
  logic                 exp_vld;
  logic [FETCH_W-1:0]   exp_inst;
  logic                 exp_inst32;
  logic                 exp_inst32_low;
  logic                 exp_expt_vld;
  logic                 exp_expt_cur;
  logic                 exp_empty;
  logic                 exp_fetch;
  int                   err_cnt;
  logic [31:0]          lfsr_q = 32'h249a;

  always #(CLK_PERIOD / 2) ibuf_pop_upd_clk = ~ibuf_pop_upd_clk;

  ibuf_top u_dut (
    .ibuf_pop_upd_clk (ibuf_pop_upd_clk),
    .cpurst_b         (cpurst_b),
    .trans_cmplt      (trans_cmplt),
    .fetch_data       (fetch_data),
    .unalign_fetch    (unalign_fetch),
    .acc_err          (acc_err),
    .inst_fetch       (inst_fetch),
    .pop_en           (pop_en),
    .inst_vld         (inst_vld),
    .inst             (inst),
    .inst32           (inst32),
    .inst32_low       (inst32_low),
    .expt_vld         (expt_vld),
    .expt_cur         (expt_cur),
    .empty            (empty),
    .ifcancel         (ifcancel)
  );

  ibuf_tb_checks u_checks (
    .ibuf_pop_upd_clk (ibuf_pop_upd_clk),
    .cpurst_b         (cpurst_b),
    .inst_vld         (inst_vld),
    .inst             (inst),
    .inst32           (inst32),
    .inst32_low       (inst32_low),
    .expt_vld         (expt_vld),
    .expt_cur         (expt_cur),
    .empty            (empty),
    .inst_fetch       (inst_fetch),
    .exp_vld          (exp_vld),
    .exp_inst         (exp_inst),
    .exp_inst32       (exp_inst32),
    .exp_inst32_low   (exp_inst32_low),
    .exp_expt_vld     (exp_expt_vld),
    .exp_expt_cur     (exp_expt_cur),
    .exp_empty        (exp_empty),
    .exp_fetch        (exp_fetch),
    .err_cnt          (err_cnt)
  );

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
      v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  // Expected outputs from the queue head
  task automatic update_expect();
    inst_len_e len;
    if (q_half.size() == 0)
      len = LEN_NONE;
    else if (q_half[0][1:0] != 2'b11)
      len = LEN_16;
    else if (q_half.size() > 1)
      len = LEN_32;
    else
      len = LEN_32_LOW;
    exp_vld         = (len == LEN_16) || (len == LEN_32);
    exp_inst32      = (len == LEN_32);
    exp_inst32_low  = (len == LEN_32_LOW);
    exp_inst[15:0]  = (q_half.size() > 0) ? q_half[0] : '0;
    exp_inst[31:16] = (q_half.size() > 1) ? q_half[1] : '0;
    exp_expt_vld    = ((len == LEN_16) && q_err[0]) ||
                      ((len == LEN_32) && (q_err[0] || q_err[1]));
    exp_expt_cur    = (q_half.size() > 0) && q_err[0];
    exp_empty       = (q_half.size() == 0);
    exp_fetch       = (ENTRY_NUM - q_half.size()) >= FETCH_MIN_FREE;
  endtask

  always @(posedge ibuf_pop_upd_clk or negedge cpurst_b)
  begin : model_upd
    int free_n;
    int pop_n;
    if (!cpurst_b || ifcancel)
    begin
      q_half.delete();
      q_err.delete();
    end
    else
    begin
      free_n = ENTRY_NUM - q_half.size();  // Room seen before this edge's pop
      pop_n  = 0;
      if (pop_en && exp_vld)
        pop_n = exp_inst32 ? 2 : 1;
      repeat (pop_n)
      begin
        void'(q_half.pop_front());
        void'(q_err.pop_front());
      end
      if (trans_cmplt && free_n >= FETCH_MIN_FREE)
      begin
        if (!unalign_fetch)
        begin
          q_half.push_back(fetch_data[15:0]);
          q_err.push_back(acc_err);
        end
        q_half.push_back(fetch_data[31:16]);
        q_err.push_back(acc_err);
      end
    end
    update_expect();
  end

  initial
  begin : stimulus
    int          phase;
    logic [31:0] pop_sel;
    ibuf_pop_upd_clk = 1'b0;
    cpurst_b         = 1'b0;
    trans_cmplt      = 1'b0;
    fetch_data       = '0;
    unalign_fetch    = 1'b0;
    acc_err          = 1'b0;
    pop_en           = 1'b0;
    ifcancel         = 1'b0;
    repeat (RST_CYC) @(posedge ibuf_pop_upd_clk);
    @(negedge ibuf_pop_upd_clk);
    cpurst_b = 1'b1;
    for (int cyc = 0; cyc < NUM_CYC; cyc++)
    begin
      @(negedge ibuf_pop_upd_clk);
      phase         = (cyc / PHASE_LEN) % 3;
      trans_cmplt   = lfsr_step();
      unalign_fetch = (rand_bits(2) == 32'd3);
      acc_err       = (rand_bits(2) == 32'd3);
      fetch_data    = rand_bits(32);
      pop_sel       = rand_bits(3);
      case (phase)
        0:       pop_en = (pop_sel == 32'd0);  // Fills up so fetches get refused
        1:       pop_en = pop_sel[0];
        default: pop_en = (pop_sel != 32'd0);  // Drains and waits on missing high halves
      endcase
      ifcancel      = (rand_bits(5) == 32'd31);
    end
    @(negedge ibuf_pop_upd_clk);
    trans_cmplt = 1'b0;
    pop_en      = 1'b0;
    ifcancel    = 1'b0;
    repeat (4) @(posedge ibuf_pop_upd_clk);
    $display("Run complete, %0d errors", err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Simulation did not finish in time, stimulus stalled");
    $display("Run stopped, %0d errors", err_cnt);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* dv/ibuf_tb_checks.sv */
// Concurrent checks of the instruction buffer outputs against the reference model
// Instantiated in the testbench top and counts every mismatch it sees

`timescale 1ns/100ps

module ibuf_tb_checks (
  input  logic                         ibuf_pop_upd_clk,
  input  logic                         cpurst_b,
  // DUT outputs
  input  logic                         inst_vld,
  input  logic [ibuf_pkg::FETCH_W-1:0] inst,
  input  logic                         inst32,
  input  logic                         inst32_low,
  input  logic                         expt_vld,
  input  logic                         expt_cur,
  input  logic                         empty,
  input  logic                         inst_fetch,
  // Reference model expectations
  input  logic                         exp_vld,
  input  logic [ibuf_pkg::FETCH_W-1:0] exp_inst,
  input  logic                         exp_inst32,
  input  logic                         exp_inst32_low,
  input  logic                         exp_expt_vld,
  input  logic                         exp_expt_cur,
  input  logic                         exp_empty,
  input  logic                         exp_fetch,
  output int                           err_cnt
);

  int fail_cnt = 0;

  assign err_cnt = fail_cnt;

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    fail_cnt++;
    $display("ERROR t=%0t %s dut=%h exp=%h", $time, name, got, exp);
  endtask

  a_inst_vld: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    inst_vld == exp_vld)
    else report_mismatch("inst_vld", 32'($sampled(inst_vld)), 32'($sampled(exp_vld)));

  a_inst32: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    inst32 == exp_inst32)
    else report_mismatch("inst32", 32'($sampled(inst32)), 32'($sampled(exp_inst32)));

  a_inst32_low: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    inst32_low == exp_inst32_low)
    else report_mismatch("inst32_low", 32'($sampled(inst32_low)),
                         32'($sampled(exp_inst32_low)));

  // Only the lower half matters for a 16-bit instruction
  a_inst16_data: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    (exp_vld && !exp_inst32) |-> (inst[15:0] == exp_inst[15:0]))
    else report_mismatch("inst[15:0]", 32'($sampled(inst[15:0])),
                         32'($sampled(exp_inst[15:0])));

  a_inst32_data: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    exp_inst32 |-> (inst == exp_inst))
    else report_mismatch("inst", $sampled(inst), $sampled(exp_inst));

  a_expt_vld: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    expt_vld == exp_expt_vld)
    else report_mismatch("expt_vld", 32'($sampled(expt_vld)), 32'($sampled(exp_expt_vld)));

  a_expt_cur: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    expt_cur == exp_expt_cur)
    else report_mismatch("expt_cur", 32'($sampled(expt_cur)), 32'($sampled(exp_expt_cur)));

  a_empty: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    empty == exp_empty)
    else report_mismatch("empty", 32'($sampled(empty)), 32'($sampled(exp_empty)));

  a_inst_fetch: assert property (@(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    inst_fetch == exp_fetch)
    else report_mismatch("inst_fetch", 32'($sampled(inst_fetch)), 32'($sampled(exp_fetch)));

endmodule

/* hdl/ibuf_top.sv */
// Instruction buffer top level
// Sits between the fetch bus interface and the decode stage consumer

`timescale 1ns/100ps

module ibuf_top (
  input  logic                         ibuf_pop_upd_clk,
  input  logic                         cpurst_b,
  // Fetch bus side
  input  logic                         trans_cmplt,
  input  logic [ibuf_pkg::FETCH_W-1:0] fetch_data,
  input  logic                         unalign_fetch,
  input  logic                         acc_err,
  output logic                         inst_fetch,
  // Decode side
  input  logic                         pop_en,
  output logic                         inst_vld,
  output logic [ibuf_pkg::FETCH_W-1:0] inst,
  output logic                         inst32,
  output logic                         inst32_low,
  output logic                         expt_vld,
  output logic                         expt_cur,
  output logic                         empty,
  // Flush
  input  logic                         ifcancel
);

  import ibuf_pkg::*;

  ptr_t  create_mask0;
  ptr_t  create_mask1;
  half_t wr_half0;
  half_t wr_half1;
  ptr_t  retire_mask;
  ptr_t  pop_ptr;
  ptr_t  entry_vld;
  half_t entry_inst [ENTRY_NUM];
  ptr_t  entry_err;

  ibuf_entry_array u_entry_array (
    .ibuf_pop_upd_clk (ibuf_pop_upd_clk),
    .cpurst_b         (cpurst_b),
    .ifcancel         (ifcancel),
    .create_mask0     (create_mask0),
    .create_mask1     (create_mask1),
    .wr_half0         (wr_half0),
    .wr_half1         (wr_half1),
    .wr_err           (acc_err),
    .retire_mask      (retire_mask),
    .entry_vld        (entry_vld),
    .entry_inst       (entry_inst),
    .entry_err        (entry_err)
  );

  ibuf_push_ctrl u_push_ctrl (
    .ibuf_pop_upd_clk (ibuf_pop_upd_clk),
    .cpurst_b         (cpurst_b),
    .ifcancel         (ifcancel),
    .trans_cmplt      (trans_cmplt),
    .unalign_fetch    (unalign_fetch),
    .fetch_data       (fetch_data),
    .entry_vld        (entry_vld),
    .pop_ptr          (pop_ptr),
    .create_mask0     (create_mask0),
    .create_mask1     (create_mask1),
    .wr_half0         (wr_half0),
    .wr_half1         (wr_half1),
    .inst_fetch       (inst_fetch)
  );

  ibuf_pop_ctrl u_pop_ctrl (
    .ibuf_pop_upd_clk (ibuf_pop_upd_clk),
    .cpurst_b         (cpurst_b),
    .ifcancel         (ifcancel),
    .pop_en           (pop_en),
    .entry_vld        (entry_vld),
    .entry_inst       (entry_inst),
    .entry_err        (entry_err),
    .pop_ptr          (pop_ptr),
    .retire_mask      (retire_mask),
    .inst_vld         (inst_vld),
    .inst             (inst),
    .inst32           (inst32),
    .inst32_low       (inst32_low),
    .expt_vld         (expt_vld),
    .expt_cur         (expt_cur),
    .empty            (empty)
  );

endmodule

/* hdl/ibuf_pop_ctrl.sv */
// Pop side of the instruction buffer
// Assembles 16 or 32 bit instructions at the head, retires them on pop_en

`timescale 1ns/100ps

module ibuf_pop_ctrl (
  input  logic                         ibuf_pop_upd_clk,
  input  logic                         cpurst_b,
  input  logic                         ifcancel,
  input  logic                         pop_en,
  input  ibuf_pkg::ptr_t               entry_vld,
  input  ibuf_pkg::half_t              entry_inst [ibuf_pkg::ENTRY_NUM],
  input  ibuf_pkg::ptr_t               entry_err,
  output ibuf_pkg::ptr_t               pop_ptr,
  output ibuf_pkg::ptr_t               retire_mask,
  output logic                         inst_vld,
  output logic [ibuf_pkg::FETCH_W-1:0] inst,
  output logic                         inst32,
  output logic                         inst32_low,
  output logic                         expt_vld,
  output logic                         expt_cur,
  output logic                         empty
);

  import ibuf_pkg::*;

  ptr_t      pop_ptr_inc1;
  ptr_t      pop_ptr_inc2;
  logic      head_vld;
  half_t     head_inst;
  logic      head_err;
  logic      next_vld;
  half_t     next_inst;
  logic      next_err;
  logic      head_is32;
  logic      retire;
  inst_len_e inst_len;

  assign pop_ptr_inc1 = {pop_ptr[ENTRY_NUM-2:0], pop_ptr[ENTRY_NUM-1]};
  assign pop_ptr_inc2 = {pop_ptr[ENTRY_NUM-3:0], pop_ptr[ENTRY_NUM-1:ENTRY_NUM-2]};

  // One-hot read muxes for the head and its successor
  always_comb
  begin
    head_vld  = 1'b0;
    head_inst = '0;
    head_err  = 1'b0;
    next_vld  = 1'b0;
    next_inst = '0;
    next_err  = 1'b0;
    for (int k = 0; k < ENTRY_NUM; k++)
    begin
      if (pop_ptr[k])
      begin
        head_vld  = head_vld | entry_vld[k];
        head_inst = head_inst | entry_inst[k];
        head_err  = head_err | entry_err[k];
      end
      if (pop_ptr_inc1[k])
      begin
        next_vld  = next_vld | entry_vld[k];
        next_inst = next_inst | entry_inst[k];
        next_err  = next_err | entry_err[k];
      end
    end
  end

  assign head_is32 = (head_inst[1:0] == 2'b11);

  always_comb
  begin
    if (!head_vld)
      inst_len = LEN_NONE;
    else if (!head_is32)
      inst_len = LEN_16;
    else if (next_vld)
      inst_len = LEN_32;
    else
      inst_len = LEN_32_LOW;
  end

  assign inst_vld   = (inst_len == LEN_16) || (inst_len == LEN_32);
  assign inst32     = (inst_len == LEN_32);
  assign inst32_low = (inst_len == LEN_32_LOW);
  assign inst       = {next_inst, head_inst};
  assign empty      = ~|entry_vld;

  // Error of any halfword the instruction consumes
  assign expt_vld = ((inst_len == LEN_16) && head_err) ||
                    ((inst_len == LEN_32) && (head_err || next_err));
  assign expt_cur = head_vld && head_err;

  assign retire      = pop_en && inst_vld && !ifcancel;
  assign retire_mask = {ENTRY_NUM{retire}} & (pop_ptr | (pop_ptr_inc1 & {ENTRY_NUM{inst32}}));

  // Pointer holds on cancel
  always_ff @(posedge ibuf_pop_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pop_ptr <= ptr_t'(1);
    else if (retire && inst32)
      pop_ptr <= pop_ptr_inc2;
    else if (retire)
      pop_ptr <= pop_ptr_inc1;
  end

  // Oldest live entry always sits at the head
  a_head_live: assert property (
    @(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    (|entry_vld) |-> head_vld
  ) else $error("valid entries behind an empty head: vld %b pop %b", entry_vld, pop_ptr);

endmodule

/* hdl/ibuf_push_ctrl.sv */
// Push side of the instruction buffer
// Steers completed fetches into the ring and raises the fetch request

`timescale 1ns/100ps

module ibuf_push_ctrl (
  input  logic                         ibuf_pop_upd_clk,
  input  logic                         cpurst_b,
  input  logic                         ifcancel,
  input  logic                         trans_cmplt,
  input  logic                         unalign_fetch,
  input  logic [ibuf_pkg::FETCH_W-1:0] fetch_data,
  input  ibuf_pkg::ptr_t               entry_vld,
  input  ibuf_pkg::ptr_t               pop_ptr,
  output ibuf_pkg::ptr_t               create_mask0,
  output ibuf_pkg::ptr_t               create_mask1,
  output ibuf_pkg::half_t              wr_half0,
  output ibuf_pkg::half_t              wr_half1,
  output logic                         inst_fetch
);

  import ibuf_pkg::*;

  localparam int CNT_W = $clog2(ENTRY_NUM + 1);

  ptr_t             push_ptr;
  ptr_t             push_ptr_inc1;
  ptr_t             push_ptr_inc2;
  logic [CNT_W-1:0] vld_num;
  logic [CNT_W-1:0] free_num;
  logic             push_accept;
  logic             push_two;

  // Valid entry count
  always_comb
  begin
    vld_num = '0;
    for (int k = 0; k < ENTRY_NUM; k++)
      vld_num = vld_num + CNT_W'(entry_vld[k]);
  end

  assign free_num   = CNT_W'(ENTRY_NUM) - vld_num;
  assign inst_fetch = (free_num >= CNT_W'(FETCH_MIN_FREE));

  // A completion without a request is dropped
  assign push_accept = trans_cmplt && inst_fetch && !ifcancel;
  assign push_two    = push_accept && !unalign_fetch;

  assign push_ptr_inc1 = {push_ptr[ENTRY_NUM-2:0], push_ptr[ENTRY_NUM-1]};
  assign push_ptr_inc2 = {push_ptr[ENTRY_NUM-3:0], push_ptr[ENTRY_NUM-1:ENTRY_NUM-2]};

  assign create_mask0 = push_ptr & {ENTRY_NUM{push_accept}};
  assign create_mask1 = push_ptr_inc1 & {ENTRY_NUM{push_two}};

  // Unaligned fetch carries only the upper halfword
  assign wr_half0 = unalign_fetch ? fetch_data[FETCH_W-1:HALF_W] : fetch_data[HALF_W-1:0];
  assign wr_half1 = fetch_data[FETCH_W-1:HALF_W];

  always_ff @(posedge ibuf_pop_upd_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      push_ptr <= ptr_t'(1);
    else if (ifcancel)
      push_ptr <= pop_ptr;  // Ring restarts at the head
    else if (push_two)
      push_ptr <= push_ptr_inc2;
    else if (push_accept)
      push_ptr <= push_ptr_inc1;
  end

  a_push_onehot: assert property (
    @(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    $onehot(push_ptr)
  ) else $error("push pointer not one-hot: %b", push_ptr);

endmodule

/* hdl/ibuf_entry_array.sv */
// Six halfword entries of the instruction buffer, each with valid and access error
// Written by the push controller masks, retired by the pop controller mask

`timescale 1ns/100ps

module ibuf_entry_array (
  input  logic             ibuf_pop_upd_clk,
  input  logic             cpurst_b,
  input  logic             ifcancel,
  input  ibuf_pkg::ptr_t   create_mask0,
  input  ibuf_pkg::ptr_t   create_mask1,
  input  ibuf_pkg::half_t  wr_half0,
  input  ibuf_pkg::half_t  wr_half1,
  input  logic             wr_err,
  input  ibuf_pkg::ptr_t   retire_mask,
  output ibuf_pkg::ptr_t   entry_vld,
  output ibuf_pkg::half_t  entry_inst [ibuf_pkg::ENTRY_NUM],
  output ibuf_pkg::ptr_t   entry_err
);

  import ibuf_pkg::*;

  ptr_t create_any;

  assign create_any = create_mask0 | create_mask1;

  genvar i;
  generate
    for (i = 0; i < ENTRY_NUM; i++)
    begin : g_entry
      logic  vld_q;
      half_t inst_q;
      logic  err_q;

      // Cancel wins over a create in the same cycle
      always_ff @(posedge ibuf_pop_upd_clk or negedge cpurst_b)
      begin
        if (!cpurst_b)
          vld_q <= 1'b0;
        else if (ifcancel)
          vld_q <= 1'b0;
        else if (create_any[i])
          vld_q <= 1'b1;
        else if (retire_mask[i])
          vld_q <= 1'b0;
      end

      always_ff @(posedge ibuf_pop_upd_clk)
      begin
        if (create_mask0[i])
          inst_q <= wr_half0;
        else if (create_mask1[i])
          inst_q <= wr_half1;
        if (create_any[i])
          err_q <= wr_err;  // Both halves share the bus error
      end

      assign entry_vld[i]  = vld_q;
      assign entry_inst[i] = inst_q;
      assign entry_err[i]  = err_q;
    end
  endgenerate

  // Push and pop pointers must never overlap on a live entry
  a_no_overwrite: assert property (
    @(posedge ibuf_pop_upd_clk) disable iff (!cpurst_b)
    ((create_any & entry_vld & ~retire_mask) == '0)
  ) else $error("create targets a valid entry: create %b vld %b retire %b",
                create_any, entry_vld, retire_mask);

endmodule

/* hdl/ibuf_pkg.sv */
// Sizes and types for the fetch-side instruction buffer
// Imported by every RTL block and by the testbench reference model

package ibuf_pkg;

  // Buffer geometry
  localparam int ENTRY_NUM      = 6;   // Halfword entries in the ring
  localparam int HALF_W         = 16;
  localparam int FETCH_W        = 32;  // Bus word and assembled instruction
  localparam int FETCH_MIN_FREE = 2;   // Room for one aligned fetch

  // One-hot entry vector, used for pointers and masks
  typedef logic [ENTRY_NUM-1:0] ptr_t;

  typedef logic [HALF_W-1:0] half_t;

  // Length of the instruction at the pop pointer
  typedef enum logic [1:0] {
    LEN_NONE   = 2'b00,  // Head entry empty
    LEN_16     = 2'b01,
    LEN_32_LOW = 2'b10,  // Low half present, high half still missing
    LEN_32     = 2'b11
  } inst_len_e;

endpackage
